/* project.f */
+incdir+hw
hw/alu_pkg.sv
hw/apb_alu_regs.sv
hw/div_unit.sv
hw/alu.sv
hw/result_regs.sv
hw/alu_apb_top.sv
bench/alu_checker.sv
bench/tb_alu.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_alu -o tb_alu_sim \
  && ./obj_dir/tb_alu_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0

/* bench/tb_alu.sv */
`timescale 1ns/10ps
`include "alu_params.svh"

module tb_alu;

  logic                clk;
  logic                arst_n;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [`ALU_AW-1:0]  paddr;
  logic [`ALU_DW-1:0]  pwdata;
  logic [`ALU_DW-1:0]  prdata;
  logic                pready;
  logic                pslverr;
  int                  test_id;
  logic                test_done;
  logic                all_done;
  int                  err_count;
  logic [`ALU_DW-1:0]  rd_data;
  logic [`ALU_OPW-1:0] ops [13];
  int                  i;

  always #10 clk = ~clk;

  alu_apb_top u_alu_apb_top (.*);

  alu_checker u_alu_checker (.*);

  task automatic to_drive_point();
    @(posedge clk);
    #2;
  endtask

  // Setup cycle, then access cycle, then back to idle
  task automatic apb_access(input logic wr, input logic [`ALU_AW-1:0] addr,
                            input logic [`ALU_DW-1:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = data;
    to_drive_point();
    penable = 1'b1;
    @(negedge clk);
    rd_data = prdata;
    to_drive_point();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_done();
    int cycles;
    cycles  = 0;
    rd_data = '0;
    while (!rd_data[`ALU_ST_DONE] && cycles < 100) begin
      apb_access(1'b0, `ALU_REG_STATUS, '0);
      cycles += 2;
    end
    if (!rd_data[`ALU_ST_DONE]) begin
      $display("error: operation never finished within 100 cycles, time %0t", $time);
      $display("sim failed");
      $finish;
    end
  endtask

  // Disturb 1 sends a second CTRL write and 2 rewrites OPA while the first op runs
  task automatic run_op(input logic [`ALU_OPW-1:0] op, input logic [`ALU_DW-1:0] a,
                        input logic [`ALU_DW-1:0] b, input int disturb);
    apb_access(1'b1, `ALU_REG_OPA, a);
    apb_access(1'b1, `ALU_REG_OPB, b);
    apb_access(1'b1, `ALU_REG_CTRL, {27'h0, op});
    case (disturb)
      1:       apb_access(1'b1, `ALU_REG_CTRL, {27'h0, alu_pkg::op_add});
      2:       apb_access(1'b1, `ALU_REG_OPA, ~a);
      default: ;
    endcase
    wait_done();
    apb_access(1'b0, `ALU_REG_RES_LO, '0);
    apb_access(1'b0, `ALU_REG_RES_HI, '0);
  endtask

  task automatic end_test(input int id);
    test_id   = id;
    test_done = 1'b1;
    to_drive_point();
    test_done = 1'b0;
  endtask

  // Corner values mixed into the random stream
  function automatic logic [`ALU_DW-1:0] pick_operand();
    case ($urandom % 6)
      0:       pick_operand = 32'h0;
      1:       pick_operand = 32'hFFFF_FFFF;
      2:       pick_operand = 32'h8000_0000;
      3:       pick_operand = $urandom % 64;
      default: pick_operand = $urandom;
    endcase
  endfunction

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    test_id   = 0;
    test_done = 1'b0;
    all_done  = 1'b0;
    ops = '{alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_add, alu_pkg::op_sub, alu_pkg::op_mul,
            alu_pkg::op_shr, alu_pkg::op_shra, alu_pkg::op_shl, alu_pkg::op_ror,
            alu_pkg::op_rol, alu_pkg::op_neg, alu_pkg::op_not, alu_pkg::op_inc};
    void'($urandom(13));
    repeat (5) @(posedge clk);
    #2;
    arst_n = 1'b1;

    apb_access(1'b0, `ALU_REG_STATUS, '0);
    apb_access(1'b0, `ALU_REG_RES_LO, '0);
    apb_access(1'b0, `ALU_REG_RES_HI, '0);
    apb_access(1'b0, 5'h18, '0);   // Unmapped offset
    end_test(1);

    repeat (200) run_op(ops[$urandom % 13], pick_operand(), pick_operand(), 0);
    end_test(2);

    for (i = 0; i < 50; i++) begin
      run_op(alu_pkg::op_div, pick_operand(), (i % 2 == 0) ? $urandom : $urandom % 1000 + 1, 0);
    end
    run_op(alu_pkg::op_div, $urandom, 32'h0, 0);
    run_op(alu_pkg::op_div, 32'h0, 32'h0, 0);
    end_test(3);

    run_op(alu_pkg::op_div, $urandom, $urandom % 256 + 1, 1);
    end_test(4);

    // Undefined codes leave the previous divide result in place
    apb_access(1'b1, `ALU_REG_CTRL, 32'h0000_0000);
    apb_access(1'b1, `ALU_REG_CTRL, 32'h0000_001F);
    apb_access(1'b1, `ALU_REG_CTRL, 32'h0000_000C);
    apb_access(1'b0, `ALU_REG_STATUS, '0);
    apb_access(1'b0, `ALU_REG_RES_LO, '0);
    apb_access(1'b0, `ALU_REG_RES_HI, '0);
    end_test(5);

    run_op(alu_pkg::op_div, $urandom | 32'h8000_0000, $urandom % 4096 + 3, 2);
    apb_access(1'b0, `ALU_REG_OPA, '0);   // Rewrite taken while busy
    apb_access(1'b0, `ALU_REG_OPB, '0);
    apb_access(1'b0, `ALU_REG_CTRL, '0);
    end_test(6);

    all_done = 1'b1;
    to_drive_point();
    all_done = 1'b0;
    if (err_count == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* bench/alu_checker.sv */
`timescale 1ns/10ps
`include "alu_params.svh"

module alu_checker (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [`ALU_AW-1:0]  paddr,
  input  logic [`ALU_DW-1:0]  pwdata,
  input  logic [`ALU_DW-1:0]  prdata,
  input  logic                pready,
  input  logic                pslverr,
  input  int                  test_id,
  input  logic                test_done,
  input  logic                all_done,
  output int                  err_count
);

  logic [`ALU_DW-1:0]   m_a;
  logic [`ALU_DW-1:0]   m_b;
  logic [`ALU_OPW-1:0]  m_op;
  logic                 pending;
  logic [2*`ALU_DW-1:0] cur_res;
  logic [2*`ALU_DW-1:0] nxt_res;
  logic [4:0]           cur_st;
  logic [4:0]           nxt_st;
  int                   cyc;
  int                   done_at;
  int                   checks;
  int                   errs;
  int                   t_checks;
  int                   t_errs;

  assign err_count = errs;

  function automatic logic is_legal(input logic [`ALU_OPW-1:0] op);
    case (op)
      alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_add, alu_pkg::op_sub, alu_pkg::op_mul,
      alu_pkg::op_div, alu_pkg::op_shr, alu_pkg::op_shra, alu_pkg::op_shl, alu_pkg::op_ror,
      alu_pkg::op_rol, alu_pkg::op_neg, alu_pkg::op_not, alu_pkg::op_inc:
        is_legal = 1'b1;
      default:
        is_legal = 1'b0;
    endcase
  endfunction

  // Returns {hi, lo} with remainder over quotient for divide
  function automatic logic [63:0] expected_result(input logic [4:0] op,
                                                   input logic [31:0] a, input logic [31:0] b);
    logic [4:0]  n;
    logic [31:0] fill;
    n    = b[4:0];
    fill = a[31] ? ~(32'hFFFF_FFFF >> n) : 32'h0;   // Sign bits shifted in
    case (op)
      alu_pkg::op_and:  expected_result = {32'h0, a & b};
      alu_pkg::op_or:   expected_result = {32'h0, a | b};
      alu_pkg::op_add:  expected_result = {32'h0, a + b};
      alu_pkg::op_sub:  expected_result = {32'h0, a - b};
      alu_pkg::op_mul:  expected_result = {32'h0, a} * {32'h0, b};
      alu_pkg::op_div:  expected_result = (b == 32'h0) ? {a, 32'hFFFF_FFFF} : {a % b, a / b};
      alu_pkg::op_shr:  expected_result = {32'h0, a >> n};
      alu_pkg::op_shra: expected_result = {32'h0, (a >> n) | fill};
      alu_pkg::op_shl:  expected_result = {32'h0, a << n};
      alu_pkg::op_ror:  expected_result = {32'h0, (a >> n) | (a << (6'd32 - n))};
      alu_pkg::op_rol:  expected_result = {32'h0, (a << n) | (a >> (6'd32 - n))};
      alu_pkg::op_neg:  expected_result = {32'h0, 32'h0 - b};
      alu_pkg::op_not:  expected_result = {32'h0, ~b};
      alu_pkg::op_inc:  expected_result = {32'h0, b + 32'h1};
      default:          expected_result = 64'h0;
    endcase
  endfunction

  function automatic logic expected_ovf(input logic [4:0] op, input logic [31:0] a,
                                        input logic [31:0] b);
    logic [32:0] s;
    s = 33'h0;
    if (op == alu_pkg::op_add) begin
      s = {a[31], a} + {b[31], b};
    end
    if (op == alu_pkg::op_sub) begin
      s = {a[31], a} - {b[31], b};
    end
    expected_ovf = (s[32] != s[31]);   // Left the signed 32-bit range
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] want, input string what);
    checks++;
    t_checks++;
    if (got !== want) begin
      errs++;
      t_errs++;
      $display("mismatch at %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, want);
    end
  endtask

  // Sampled mid-cycle while the access phase is stable
  always @(negedge clk or negedge arst_n) begin
    if (!arst_n) begin
      m_a      = '0;
      m_b      = '0;
      m_op     = '0;
      pending  = 1'b0;
      cur_res  = '0;
      nxt_res  = '0;
      cur_st   = '0;
      nxt_st   = '0;
      cyc      = 0;
      done_at  = 0;
      checks   = 0;
      errs     = 0;
      t_checks = 0;
      t_errs   = 0;
    end else begin
      if (pending && cyc >= done_at) begin   // Result captured and done raised
        pending = 1'b0;
        cur_res = nxt_res;
        cur_st  = nxt_st;
      end
      if (psel && penable) begin
        check({31'h0, pready}, 32'h1, "pready");
        if (pwrite) begin
          check({31'h0, pslverr},
                {31'h0, (paddr == `ALU_REG_CTRL) && (!is_legal(pwdata[4:0]) || pending)},
                "pslverr on write");
          case (paddr)
            `ALU_REG_OPA: m_a = pwdata;
            `ALU_REG_OPB: m_b = pwdata;
            `ALU_REG_CTRL: begin
              if (is_legal(pwdata[4:0]) && !pending) begin
                m_op    = pwdata[4:0];
                nxt_res = expected_result(m_op, m_a, m_b);
                nxt_st  = {(m_op == alu_pkg::op_div) && (m_b == 32'h0),
                           expected_ovf(m_op, m_a, m_b), nxt_res == 64'h0, 2'b10};
                // Cycle in which done becomes visible
                done_at = cyc + ((m_op == alu_pkg::op_div) ? `ALU_DW + 3 : 3);
                pending = 1'b1;
              end
            end
            default: ;
          endcase
        end else begin
          check({31'h0, pslverr}, 32'h0, "pslverr on read");
          case (paddr)
            `ALU_REG_OPA:    check(prdata, m_a, "OPA");
            `ALU_REG_OPB:    check(prdata, m_b, "OPB");
            `ALU_REG_CTRL:   check(prdata, {27'h0, m_op}, "CTRL");
            `ALU_REG_STATUS: check(prdata, pending ? 32'h1 : {27'h0, cur_st}, "status");
            `ALU_REG_RES_LO: check(prdata, cur_res[31:0], "RES_LO");
            `ALU_REG_RES_HI: check(prdata, cur_res[63:32], "RES_HI");
            default:         check(prdata, 32'h0, "unmapped read");
          endcase
        end
      end
      if (test_done) begin
        $display("test %0d: %0d checks, %0d errors", test_id, t_checks, t_errs);
        t_checks = 0;
        t_errs   = 0;
      end
      if (all_done) begin
        $display("total: %0d checks, %0d errors", checks, errs);
      end
      cyc++;
    end
  end

endmodule

/* hw/alu_apb_top.sv */
`timescale 1ns/10ps
`include "alu_params.svh"

module alu_apb_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [`ALU_AW-1:0]  paddr,
  input  logic [`ALU_DW-1:0]  pwdata,
  output logic [`ALU_DW-1:0]  prdata,
  output logic                pready,
  output logic                pslverr
);

  logic [`ALU_DW-1:0]   op_a;
  logic [`ALU_DW-1:0]   op_b;
  alu_pkg::alu_op_e     opcode;
  logic                 start;
  alu_pkg::alu_result_u result;
  logic                 res_valid;
  logic                 ovf_flag;
  logic                 dz_flag;
  logic [`ALU_DW-1:0]   res_lo;
  logic [`ALU_DW-1:0]   res_hi;
  logic                 busy;
  logic                 done;
  logic                 zero;
  logic                 ovf;
  logic                 dz;

  // Input side
  apb_alu_regs u_apb_alu_regs (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .res_lo  (res_lo),
    .res_hi  (res_hi),
    .busy    (busy),
    .done    (done),
    .zero    (zero),
    .ovf     (ovf),
    .dz      (dz),
    .op_a    (op_a),
    .op_b    (op_b),
    .opcode  (opcode),
    .start   (start)
  );

  alu u_alu (
    .clk       (clk),
    .arst_n    (arst_n),
    .op_a      (op_a),
    .op_b      (op_b),
    .opcode    (opcode),
    .start     (start),
    .result    (result),
    .res_valid (res_valid),
    .ovf_flag  (ovf_flag),
    .dz_flag   (dz_flag)
  );

  // Output side
  result_regs u_result_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .result    (result),
    .res_valid (res_valid),
    .ovf_flag  (ovf_flag),
    .dz_flag   (dz_flag),
    .res_lo    (res_lo),
    .res_hi    (res_hi),
    .busy      (busy),
    .done      (done),
    .zero      (zero),
    .ovf       (ovf),
    .dz        (dz)
  );

endmodule

/* hw/result_regs.sv */
`timescale 1ns/10ps
`include "alu_params.svh"

module result_regs (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  start,
  input  alu_pkg::alu_result_u  result,
  input  logic                  res_valid,
  input  logic                  ovf_flag,
  input  logic                  dz_flag,
  output logic [`ALU_DW-1:0]    res_lo,
  output logic [`ALU_DW-1:0]    res_hi,
  output logic                  busy,
  output logic                  done,
  output logic                  zero,
  output logic                  ovf,
  output logic                  dz
);

  alu_pkg::alu_result_u res_q;

  assign res_lo = res_q.wide.lo;
  assign res_hi = res_q.wide.hi;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_q <= '0;
      busy  <= 1'b0;
      done  <= 1'b0;
      zero  <= 1'b0;
      ovf   <= 1'b0;
      dz    <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
      done <= 1'b0;
      zero <= 1'b0;   // Flags belong to the new operation
      ovf  <= 1'b0;
      dz   <= 1'b0;
    end else if (res_valid) begin
      res_q <= result;
      busy  <= 1'b0;
      done  <= 1'b1;
      zero  <= (result.wide == '0);  // Whole 64-bit word
      ovf   <= ovf_flag;
      dz    <= dz_flag;
    end
  end

endmodule

/* hw/alu.sv */
`timescale 1ns/10ps
`include "alu_params.svh"

module alu (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`ALU_DW-1:0]    op_a,
  input  logic [`ALU_DW-1:0]    op_b,
  input  alu_pkg::alu_op_e      opcode,
  input  logic                  start,
  output alu_pkg::alu_result_u  result,
  output logic                  res_valid,
  output logic                  ovf_flag,
  output logic                  dz_flag
);

  logic [`ALU_DW-1:0]   lo_w;
  logic [`ALU_DW-1:0]   hi_w;
  logic                 ovf_w;
  logic [`ALU_DW-1:0]   sum_w;
  logic [`ALU_DW-1:0]   dif_w;
  logic [2*`ALU_DW-1:0] mul_w;
  logic [2*`ALU_DW-1:0] ror_w;
  logic [2*`ALU_DW-1:0] rol_w;
  logic [4:0]           amt;
  logic                 is_div;
  logic                 div_pend;
  logic                 div_start;
  logic [`ALU_DW-1:0]   div_a;
  logic [`ALU_DW-1:0]   div_b;
  logic [`ALU_DW-1:0]   quo;
  logic [`ALU_DW-1:0]   rem;
  logic                 div_done;

  assign amt    = op_b[4:0];
  assign is_div = (opcode == alu_pkg::op_div);
  assign sum_w  = op_a + op_b;
  assign dif_w  = op_a - op_b;
  assign mul_w  = {{`ALU_DW{1'b0}}, op_a} * {{`ALU_DW{1'b0}}, op_b};
  assign ror_w  = {op_a, op_a} >> amt;   // Low half is the rotated word
  assign rol_w  = {op_a, op_a} << amt;   // High half is the rotated word

  always_comb begin
    lo_w  = '0;
    hi_w  = '0;
    ovf_w = 1'b0;
    case (opcode)
      alu_pkg::op_and:  lo_w = op_a & op_b;
      alu_pkg::op_or:   lo_w = op_a | op_b;
      alu_pkg::op_add: begin
        lo_w  = sum_w;
        ovf_w = (op_a[`ALU_DW-1] == op_b[`ALU_DW-1]) &&
                (sum_w[`ALU_DW-1] != op_a[`ALU_DW-1]);
      end
      alu_pkg::op_sub: begin
        lo_w  = dif_w;
        ovf_w = (op_a[`ALU_DW-1] != op_b[`ALU_DW-1]) &&
                (dif_w[`ALU_DW-1] != op_a[`ALU_DW-1]);
      end
      alu_pkg::op_mul: begin
        lo_w = mul_w[`ALU_DW-1:0];
        hi_w = mul_w[2*`ALU_DW-1:`ALU_DW];
      end
      alu_pkg::op_shr:  lo_w = op_a >> amt;
      alu_pkg::op_shra: lo_w = $signed(op_a) >>> amt;
      alu_pkg::op_shl:  lo_w = op_a << amt;
      alu_pkg::op_ror:  lo_w = ror_w[`ALU_DW-1:0];
      alu_pkg::op_rol:  lo_w = rol_w[2*`ALU_DW-1:`ALU_DW];
      // Unary ops take operand B, as in the CPU datapath
      alu_pkg::op_neg:  lo_w = -op_b;
      alu_pkg::op_not:  lo_w = ~op_b;
      alu_pkg::op_inc:  lo_w = op_b + 1'b1;
      default:          lo_w = '0;
    endcase
  end

  // Divider takes its operands at start
  assign div_start = start && is_div;
  assign div_a     = op_a;
  assign div_b     = op_b;

  div_unit u_div_unit (
    .clk       (clk),
    .arst_n    (arst_n),
    .div_start (div_start),
    .div_a     (div_a),
    .div_b     (div_b),
    .quo       (quo),
    .rem       (rem),
    .div_done  (div_done)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result    <= '0;
      res_valid <= 1'b0;
      ovf_flag  <= 1'b0;
      dz_flag   <= 1'b0;
      div_pend  <= 1'b0;
    end else begin
      res_valid <= 1'b0;
      if (start) begin
        ovf_flag <= ovf_w;
        dz_flag  <= is_div && (op_b == '0);
        div_pend <= is_div;
        if (!is_div) begin
          result.wide.hi <= hi_w;
          result.wide.lo <= lo_w;
          res_valid      <= 1'b1;
        end
      end else if (div_pend && div_done) begin
        result.div.rem <= rem;
        result.div.quo <= quo;
        res_valid      <= 1'b1;
        div_pend       <= 1'b0;
      end
    end
  end

endmodule

/* hw/div_unit.sv */
`timescale 1ns/10ps
`include "alu_params.svh"

module div_unit (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                div_start,
  input  logic [`ALU_DW-1:0]  div_a,
  input  logic [`ALU_DW-1:0]  div_b,
  output logic [`ALU_DW-1:0]  quo,
  output logic [`ALU_DW-1:0]  rem,
  output logic                div_done
);

  localparam int CW = $clog2(`ALU_DIV_CYCLES + 1);

  logic [`ALU_DW-1:0] dvs_q;
  logic [CW-1:0]      cnt_q;
  logic               run_q;
  logic [`ALU_DW-1:0] src_rem;
  logic [`ALU_DW-1:0] src_quo;
  logic [`ALU_DW-1:0] src_dvs;
  logic [`ALU_DW-1:0] nxt_rem;
  logic [`ALU_DW-1:0] nxt_quo;
  logic [`ALU_DW:0]   trial;

  // One shift-subtract step, first one straight from the inputs
  always_comb begin
    src_rem = div_start ? '0 : rem;
    src_quo = div_start ? div_a : quo;
    src_dvs = div_start ? div_b : dvs_q;
    trial   = {src_rem, src_quo[`ALU_DW-1]} - {1'b0, src_dvs};
    if (trial[`ALU_DW]) begin            // Borrow, restore
      nxt_rem = {src_rem[`ALU_DW-2:0], src_quo[`ALU_DW-1]};
      nxt_quo = {src_quo[`ALU_DW-2:0], 1'b0};
    end else begin
      nxt_rem = trial[`ALU_DW-1:0];
      nxt_quo = {src_quo[`ALU_DW-2:0], 1'b1};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      quo      <= '0;
      rem      <= '0;
      dvs_q    <= '0;
      cnt_q    <= '0;
      run_q    <= 1'b0;
      div_done <= 1'b0;
    end else begin
      div_done <= 1'b0;
      if (div_start) begin
        quo   <= nxt_quo;
        rem   <= nxt_rem;
        dvs_q <= div_b;
        cnt_q <= CW'(`ALU_DIV_CYCLES - 1);  // Steps left after this one
        run_q <= 1'b1;
      end else if (run_q) begin
        quo   <= nxt_quo;
        rem   <= nxt_rem;
        cnt_q <= cnt_q - 1'b1;
        if (cnt_q == CW'(1)) begin
          run_q    <= 1'b0;
          div_done <= 1'b1;
        end
      end
    end
  end

endmodule

/* hw/apb_alu_regs.sv */
`timescale 1ns/10ps
`include "alu_params.svh"

module apb_alu_regs (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  logic [`ALU_AW-1:0]    paddr,
  input  logic [`ALU_DW-1:0]    pwdata,
  output logic [`ALU_DW-1:0]    prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  logic [`ALU_DW-1:0]    res_lo,
  input  logic [`ALU_DW-1:0]    res_hi,
  input  logic                  busy,
  input  logic                  done,
  input  logic                  zero,
  input  logic                  ovf,
  input  logic                  dz,
  output logic [`ALU_DW-1:0]    op_a,
  output logic [`ALU_DW-1:0]    op_b,
  output alu_pkg::alu_op_e      opcode,
  output logic                  start
);

  logic wr_acc;
  logic ctrl_wr;
  logic ctrl_ok;

  function automatic logic op_legal(input logic [`ALU_OPW-1:0] code);
    case (code)
      alu_pkg::op_and, alu_pkg::op_or, alu_pkg::op_add, alu_pkg::op_sub,
      alu_pkg::op_mul, alu_pkg::op_div, alu_pkg::op_shr, alu_pkg::op_shra,
      alu_pkg::op_shl, alu_pkg::op_ror, alu_pkg::op_rol, alu_pkg::op_neg,
      alu_pkg::op_not, alu_pkg::op_inc:
        op_legal = 1'b1;
      default:
        op_legal = 1'b0;
    endcase
  endfunction

  assign wr_acc  = psel && penable && pwrite;
  assign ctrl_wr = wr_acc && (paddr == `ALU_REG_CTRL);
  // Start in flight counts as busy too
  assign ctrl_ok = ctrl_wr && op_legal(pwdata[`ALU_OPW-1:0]) && !(busy || start);

  assign pready  = 1'b1;           // No wait states
  assign pslverr = ctrl_wr && !ctrl_ok;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_a   <= '0;
      op_b   <= '0;
      opcode <= alu_pkg::alu_op_e'('0);
      start  <= 1'b0;
    end else begin
      start <= ctrl_ok;
      if (wr_acc && (paddr == `ALU_REG_OPA)) begin
        op_a <= pwdata;
      end
      if (wr_acc && (paddr == `ALU_REG_OPB)) begin
        op_b <= pwdata;
      end
      if (ctrl_ok) begin
        opcode <= alu_pkg::alu_op_e'(pwdata[`ALU_OPW-1:0]);
      end
    end
  end

  always_comb begin
    prdata = '0;
    case (paddr)
      `ALU_REG_OPA:    prdata = op_a;
      `ALU_REG_OPB:    prdata = op_b;
      `ALU_REG_CTRL:   prdata[`ALU_OPW-1:0] = opcode;
      `ALU_REG_STATUS: begin
        prdata[`ALU_ST_BUSY] = busy;
        prdata[`ALU_ST_DONE] = done;
        prdata[`ALU_ST_ZERO] = zero;
        prdata[`ALU_ST_OVF]  = ovf;
        prdata[`ALU_ST_DZ]   = dz;
      end
      `ALU_REG_RES_LO: prdata = res_lo;
      `ALU_REG_RES_HI: prdata = res_hi;
      default:         prdata = '0;  // Unmapped reads as zero
    endcase
  end

endmodule

/* hw/alu_pkg.sv */
`include "alu_params.svh"

package alu_pkg;

  // Encodings carried over from the CPU datapath
  typedef enum logic [`ALU_OPW-1:0] {
    op_add  = 5'b00011,
    op_sub  = 5'b00100,
    op_shr  = 5'b00101,
    op_shra = 5'b00110,
    op_shl  = 5'b00111,
    op_ror  = 5'b01000,
    op_rol  = 5'b01001,
    op_and  = 5'b01010,
    op_or   = 5'b01011,
    op_mul  = 5'b01111,
    op_div  = 5'b10000,
    op_neg  = 5'b10001,
    op_not  = 5'b10010,
    op_inc  = 5'b11011
  } alu_op_e;

  typedef struct packed {
    logic [`ALU_DW-1:0] hi;
    logic [`ALU_DW-1:0] lo;
  } alu_wide_t;

  typedef struct packed {
    logic [`ALU_DW-1:0] rem;
    logic [`ALU_DW-1:0] quo;
  } alu_div_t;

  // Remainder sits in the high word, quotient in the low word
  typedef union packed {
    alu_wide_t wide;
    alu_div_t  div;
  } alu_result_u;

endpackage

/* hw/alu_params.svh */
`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// Datapath and bus widths
`define ALU_DW 32
`define ALU_AW 5

// APB register map, byte offsets
`define ALU_REG_OPA    5'h00
`define ALU_REG_OPB    5'h04
`define ALU_REG_CTRL   5'h08
`define ALU_REG_STATUS 5'h0C
`define ALU_REG_RES_LO 5'h10
`define ALU_REG_RES_HI 5'h14

// Status register bit positions
`define ALU_ST_BUSY 0
`define ALU_ST_DONE 1
`define ALU_ST_ZERO 2
`define ALU_ST_OVF  3
`define ALU_ST_DZ   4

// Opcode field width in CTRL
`define ALU_OPW 5

// One quotient bit per iteration
`define ALU_DIV_CYCLES 32

`endif
